/* source/link_pkg.sv */
package link_pkg;

  // one byte as it travels over the spi link
  typedef logic [7:0] byte_t;

  // bit position inside a link byte, wraps after eight bits
  typedef logic [2:0] bit_idx_t;

  // flops in the sck and cs_n synchronizers
  // edge detect looks at the two oldest stages
  localparam int sync_depth = 3;

  // mosi needs one stage less to line up with the detected edge
  localparam int mosi_depth = sync_depth - 1;

  // idle levels of the pins as seen before the first frame
  localparam logic sck_idle  = 1'b0;
  localparam logic cs_n_idle = 1'b1;

endpackage

/* source/cmd_pkg.sv */
package cmd_pkg;

  // command opcodes, first byte of every frame
  typedef enum logic [7:0] {
    get_cookie  = 8'd0,
    bram_poke   = 8'd1,
    bram_peek   = 8'd2,
    get_version = 8'd15
  } opcode_t;

  // parameter slot, three slots at most (poke)
  typedef logic [1:0] param_idx_t;

  // parameter counts per command
  localparam param_idx_t poke_params = 2'd3; // addr lo, addr hi, data
  localparam param_idx_t peek_params = 2'd2; // addr lo, addr hi

  // identity byte the host looks for
  localparam link_pkg::byte_t cookie = 8'haf;

  // firmware version, packed major:minor into one byte
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  // 8'h03 with the values above
  localparam link_pkg::byte_t version_byte = {version_major, version_minor};

endpackage

/* source/spi_rx.sv */
`timescale 1ns/1ps

module spi_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sck,
  input  logic            mosi,
  input  logic            cs_n,
  output link_pkg::byte_t rx_byte,
  output logic            rx_strobe,
  output logic            frame_start,
  output logic            sck_fall,
  output logic            cs_active
);

  import link_pkg::*;

  logic [sync_depth-1:0] sck_sync;  // [0] newest
  logic [sync_depth-1:0] cs_sync;
  logic [mosi_depth-1:0] mosi_sync;
  logic                  sck_rise;
  logic                  mosi_bit;
  bit_idx_t              bit_cnt;

  // pin synchronizers, all three shift in every clock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sync  <= {sync_depth{sck_idle}};
      cs_sync   <= {sync_depth{cs_n_idle}}; // frame inactive after reset
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[sync_depth-2:0], sck};
      cs_sync   <= {cs_sync[sync_depth-2:0], cs_n};
      mosi_sync <= {mosi_sync[mosi_depth-2:0], mosi};
    end
  end

  // edges from the two oldest stages
  assign sck_rise  = (sck_sync[sync_depth-1 -: 2] == 2'b01);
  assign sck_fall  = (sck_sync[sync_depth-1 -: 2] == 2'b10);
  assign cs_active = ~cs_sync[sync_depth-2];
  assign mosi_bit  = mosi_sync[mosi_depth-1]; // same age as sck_sync[sync_depth-2]

  // bit counter and strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      rx_strobe   <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      rx_strobe   <= cs_active && sck_rise && (bit_cnt == 3'd7); // byte complete
      frame_start <= (cs_sync[sync_depth-1 -: 2] == 2'b10);     // cs_n falling
      if (!cs_active)
        bit_cnt <= '0; // realign on every frame
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1; // wraps to 0 after bit 7
    end
  end

  // msb first, the shift register itself is the received byte
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_byte <= {rx_byte[6:0], mosi_bit};
  end

endmodule

/* source/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser (
  input  logic              clk,
  input  logic              rst_n,
  input  link_pkg::byte_t   rx_byte,
  input  logic              rx_strobe,
  input  logic              frame_start,
  output cmd_pkg::opcode_t  opcode,
  output link_pkg::byte_t   param0,
  output link_pkg::byte_t   param1,
  output link_pkg::byte_t   param2,
  output logic              action
);

  import cmd_pkg::*;

  typedef enum logic [1:0] {
    idle,
    read_params,
    skip_reply
  } state_t;

  state_t     state;
  param_idx_t params_left; // bytes still expected
  param_idx_t slot;        // where the next byte goes

  // control path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= idle;
      params_left <= '0;
      slot        <= '0;
      action      <= 1'b0;
    end else begin
      action <= 1'b0; // single cycle pulse
      if (frame_start) begin
        state <= idle; // new frame always starts with an opcode
      end else if (rx_strobe) begin
        case (state)
          idle: begin
            slot <= '0;
            case (opcode_t'(rx_byte))
              get_cookie, get_version: begin
                action <= 1'b1;     // no parameters, answer right away
                state  <= skip_reply;
              end
              bram_poke: begin
                params_left <= poke_params;
                state       <= read_params;
              end
              bram_peek: begin
                params_left <= peek_params;
                state       <= read_params;
              end
              default: state <= idle; // unknown opcode, dropped
            endcase
          end
          read_params: begin
            if (params_left == 2'd1) begin
              action <= 1'b1;
              // only peek answers among the commands with parameters
              state  <= (opcode == bram_peek) ? skip_reply : idle;
            end else begin
              params_left <= params_left - 2'd1;
              slot        <= slot + 2'd1;
            end
          end
          skip_reply: state <= idle; // host dummy byte while we answer
          default:    state <= idle;
        endcase
      end
    end
  end

  // opcode and parameter bytes, held until overwritten
  always_ff @(posedge clk) begin
    if (rx_strobe && !frame_start) begin
      if (state == idle)
        opcode <= opcode_t'(rx_byte);
      if (state == read_params) begin
        case (slot)
          2'd0:    param0 <= rx_byte; // addr lo
          2'd1:    param1 <= rx_byte; // addr hi
          default: param2 <= rx_byte; // poke data
        endcase
      end
    end
  end

endmodule

/* source/cmd_exec.sv */
`timescale 1ns/1ps

module cmd_exec #(
  parameter int mem_addr_w = 15
) (
  input  logic             clk,
  input  logic             rst_n,
  input  cmd_pkg::opcode_t opcode,
  input  link_pkg::byte_t  param0,
  input  link_pkg::byte_t  param1,
  input  link_pkg::byte_t  param2,
  input  logic             action,
  output link_pkg::byte_t  resp_byte,
  output logic             resp_load
);

  import link_pkg::*;
  import cmd_pkg::*;

  localparam int mem_depth = 1 << mem_addr_w;

  byte_t                 mem [mem_depth]; // single port, inferred
  byte_t                 ram_q;           // read data register
  logic [15:0]           addr_word;
  logic [mem_addr_w-1:0] addr;
  logic                  do_poke;
  logic                  do_peek;
  logic                  do_const;        // cookie or version
  logic                  peek_q;          // ram_q valid next cycle

  // high byte on top, upper bits beyond the ram size are ignored
  assign addr_word = {param1, param0};
  assign addr      = addr_word[mem_addr_w-1:0];

  assign do_poke  = action && (opcode == bram_poke);
  assign do_peek  = action && (opcode == bram_peek);
  assign do_const = action && ((opcode == get_cookie) || (opcode == get_version));

  // ram port, write or read, never both
  always_ff @(posedge clk) begin
    if (do_poke)
      mem[addr] <= param2;
    else if (do_peek)
      ram_q <= mem[addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      peek_q    <= 1'b0;
      resp_load <= 1'b0;
    end else begin
      peek_q    <= do_peek;
      resp_load <= peek_q || do_const; // peek two cycles, constants one
    end
  end

  // response byte for the transmit stage
  always_ff @(posedge clk) begin
    if (peek_q)
      resp_byte <= ram_q;
    else if (do_const)
      resp_byte <= (opcode == get_cookie) ? cookie : version_byte;
  end

endmodule

/* source/spi_tx.sv */
`timescale 1ns/1ps

module spi_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  link_pkg::byte_t resp_byte,
  input  logic            resp_load,
  input  logic            sck_fall,
  input  logic            cs_active,
  output logic            miso
);

  import link_pkg::*;

  logic     pending; // byte waiting for the next falling edge
  logic     sending;
  bit_idx_t bit_cnt;
  byte_t    shreg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
      sending <= 1'b0;
      bit_cnt <= '0;
    end else if (!cs_active) begin
      pending <= 1'b0; // frame over, drop anything left
      sending <= 1'b0;
      bit_cnt <= '0;
    end else begin
      if (resp_load)
        pending <= 1'b1;
      if (sck_fall) begin
        if (pending) begin
          pending <= 1'b0;
          sending <= 1'b1;
          bit_cnt <= '0;
        end else if (sending) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            sending <= 1'b0; // eighth bit has been sampled
        end
      end
    end
  end

  // msb first
  always_ff @(posedge clk) begin
    if (sck_fall) begin
      if (pending)
        shreg <= resp_byte;
      else
        shreg <= {shreg[6:0], 1'b0};
    end
  end

  // driven low outside a reply, no tristate
  assign miso = (cs_active && sending) ? shreg[7] : 1'b0;

endmodule

/* source/trs_link_top.sv */
`timescale 1ns/1ps

module trs_link_top #(
  parameter int mem_addr_w = 15 // 32k of ram by default
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic mosi,
  input  logic cs_n,
  output logic miso
);

  import link_pkg::*;
  import cmd_pkg::*;

  // receive -> parse
  byte_t   rx_byte;
  logic    rx_strobe;
  logic    frame_start;
  logic    sck_fall;  // also used by transmit
  logic    cs_active;

  // parse -> execute
  opcode_t opcode;
  byte_t   param0;
  byte_t   param1;
  byte_t   param2;
  logic    action;

  // execute -> transmit
  byte_t   resp_byte;
  logic    resp_load;

  spi_rx spi_rx_i (
    .clk, .rst_n, .sck, .mosi, .cs_n,
    .rx_byte, .rx_strobe, .frame_start, .sck_fall, .cs_active
  );

  cmd_parser cmd_parser_i (
    .clk, .rst_n, .rx_byte, .rx_strobe, .frame_start,
    .opcode, .param0, .param1, .param2, .action
  );

  cmd_exec #(
    .mem_addr_w(mem_addr_w)
  ) cmd_exec_i (
    .clk, .rst_n, .opcode, .param0, .param1, .param2, .action,
    .resp_byte, .resp_load
  );

  spi_tx spi_tx_i (
    .clk, .rst_n, .resp_byte, .resp_load, .sck_fall, .cs_active,
    .miso
  );

endmodule

/* sim/link_checker.sv */
`timescale 1ns/1ps

module link_checker (
  input  logic       clk,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       miso,
  input  logic       arm,        // one cycle, ahead of an answering frame
  input  logic [7:0] expected,
  input  int         reply_slot, // byte slot of the reply inside the frame
  output int         err_count,
  output int         check_count
);

  logic       sck_q = 1'b0;
  logic       cs_n_q = 1'b1;
  logic       armed = 1'b0;
  logic       noisy = 1'b0; // stray miso already reported in this frame
  logic [7:0] exp_q = 8'h00;
  logic [7:0] got = 8'h00;
  int         slot_q = 0;
  int         bit_idx = 0;  // sck rises seen in this frame
  int         got_bits = 0; // reply bits collected so far
  int         errs = 0;
  int         checks = 0;

  assign err_count   = errs;
  assign check_count = checks;

  // pins only change on the falling clk edge, so they are settled here
  always @(posedge clk) begin
    if (arm) begin
      exp_q    = expected;
      slot_q   = reply_slot;
      armed    = 1'b1;
      got_bits = 0;
    end
    // frame without a reply, miso stays low from start to end
    if (!cs_n && !armed && (miso !== 1'b0) && !noisy) begin
      $display("Fail at %0t: miso expected 0, got %b", $time, miso);
      errs++;
      noisy = 1'b1;
    end
    if (!cs_n && sck && !sck_q) begin // host samples miso on this edge
      if (armed && (bit_idx / 8 == slot_q) && (got_bits < 8)) begin
        got = {got[6:0], miso}; // msb first
        got_bits++;
        if (got_bits == 8) begin
          checks++;
          if (got !== exp_q) begin
            $display("Fail at %0t: resp_byte expected %h, got %h", $time, exp_q, got);
            errs++;
          end
        end
      end else if (armed && (miso !== 1'b0)) begin
        // outside a reply slot the line must stay quiet
        $display("Fail at %0t: miso expected 0, got %b", $time, miso);
        errs++;
      end
      bit_idx++;
    end
    if (cs_n && !cs_n_q) begin // frame over
      if (armed && (got_bits < 8)) begin
        $display("response missing: frame ended before eight bits");
        errs++;
      end
      armed   = 1'b0;
      noisy   = 1'b0;
      bit_idx = 0;
    end
    sck_q  = sck;
    cs_n_q = cs_n;
  end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       sck;
  logic       mosi;
  logic       cs_n;
  logic       miso;
  logic       arm;
  logic [7:0] exp_byte;
  int         reply_slot;
  int         err_count;
  int         check_count;
  int         tb_errors = 0;
  int         n_lines = 0;               // all lines of the case file
  int         cycles = 0;
  int         cycle_limit = 1000000000;  // real value set once the cases are known

  // case table, one entry per data line
  logic [7:0] q_op[$];
  int         q_n[$];
  logic [7:0] q_p0[$];
  logic [7:0] q_p1[$];
  logic [7:0] q_p2[$];
  int         q_ans[$];
  logic [7:0] q_exp[$];

  trs_link_top #(
    .mem_addr_w(15)
  ) trs_link_top_i (
    .clk, .rst_n, .sck, .mosi, .cs_n, .miso
  );

  link_checker link_checker_i (
    .clk, .sck, .cs_n, .miso, .arm, .expected(exp_byte), .reply_slot,
    .err_count, .check_count
  );

  always #50 clk = ~clk; // 100 ns

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic load_cases();
    int         fd;
    string      line;
    logic [7:0] op, p0, p1, p2, ex;
    int         n, ans;
    fd = $fopen("sim/link_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open case file sim/link_cases.txt");
      tb_errors++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0)
        break;
      n_lines++;
      if (line.len() < 2 || line.getc(0) == "#")
        continue; // blank or comment
      if ($sscanf(line, "%h %h %h %h %h %h %h", op, n, p0, p1, p2, ans, ex) == 7) begin
        q_op.push_back(op);
        q_n.push_back(n);
        q_p0.push_back(p0);
        q_p1.push_back(p1);
        q_p2.push_back(p2);
        q_ans.push_back(ans);
        q_exp.push_back(ex);
      end else begin
        $display("malformed line %0d in case file", n_lines);
        tb_errors++;
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_half_period();
    repeat (20) @(negedge clk);
  endtask

  // mode 0 byte, mosi moves while sck is low
  task automatic shift_byte(input logic [7:0] b);
    logic [7:0] sh;
    sh = b;
    repeat (8) begin
      mosi = sh[7];
      wait_half_period();
      sck = 1'b1;
      wait_half_period();
      sck = 1'b0;
      sh = {sh[6:0], 1'b0};
    end
  endtask

  // n below the opcode's parameter count cuts the frame short
  task automatic run_frame(input logic [7:0] op, input int n,
                           input logic [7:0] p0, input logic [7:0] p1, input logic [7:0] p2,
                           input int answer, input logic [7:0] expected);
    if (answer != 0) begin
      exp_byte   = expected;
      reply_slot = n + 1; // slot right after the last request byte
      arm        = 1'b1;
      @(negedge clk);
      arm        = 1'b0;
    end
    cs_n = 1'b0;
    wait_half_period();
    shift_byte(op);
    if (n > 0) shift_byte(p0);
    if (n > 1) shift_byte(p1);
    if (n > 2) shift_byte(p2);
    if (answer != 0) shift_byte(8'h00); // dummy, reply comes back meanwhile
    wait_half_period();
    cs_n = 1'b1;
    repeat (4) wait_half_period(); // gap between frames
  endtask

  task automatic show_counts();
    $display("errors: %0d  checks: %0d", tb_errors + err_count, check_count);
  endtask

  initial begin
    logic [31:0] seed;
    logic [14:0] addr;
    logic [7:0]  data;
    rst_n      = 1'b0;
    sck        = 1'b0;
    mosi       = 1'b0;
    cs_n       = 1'b1;
    arm        = 1'b0;
    exp_byte   = 8'h00;
    reply_slot = 0;
    load_cases();
    // 32 random frames, up to 4 bytes of 8 bits at 40 clk each
    cycle_limit = (n_lines + 32) * 4 * 8 * 40 + 1000;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) wait_half_period();
    for (int k = 0; k < q_op.size(); k++)
      run_frame(q_op[k], q_n[k], q_p0[k], q_p1[k], q_p2[k], q_ans[k], q_exp[k]);
    seed = 32'h28d;
    for (int i = 0; i < 16; i++) begin
      seed = lcg_next(seed);
      addr = {seed[10:0], i[3:0]}; // index in the low bits keeps them apart
      data = seed[23:16];
      run_frame(8'h01, 3, addr[7:0], {1'b0, addr[14:8]}, data, 0, 8'h00);
      run_frame(8'h02, 2, addr[7:0], {1'b0, addr[14:8]}, 8'h00, 1, data);
    end
    repeat (10) @(negedge clk);
    show_counts();
    if ((tb_errors + err_count == 0) && (check_count > 0))
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog
  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: test did not finish");
    show_counts();
    $display("Test failed");
    $finish;
  end

endmodule

/* sim/link_cases.txt */
# opcode nparams p0 p1 p2 answer expected, all hex, p0 p1 = addr lo hi, p2 = data
# nparams below the opcode's count cuts the frame short
00 0 00 00 00 1 af
0f 0 00 00 00 1 03
01 3 34 12 5a 0 00
02 2 34 12 00 1 5a
01 3 34 52 c3 0 00
02 2 34 12 00 1 5a
02 2 34 52 00 1 c3
63 0 00 00 00 0 00
00 0 00 00 00 1 af
01 1 34 00 00 0 00
02 2 34 12 00 1 5a
00 0 00 00 00 1 af
01 2 34 12 00 0 00
02 2 34 12 00 1 5a
0f 0 00 00 00 1 03
01 3 00 00 11 0 00
02 2 00 00 00 1 11
01 3 ff 7f ee 0 00
02 2 ff 7f 00 1 ee
02 2 ff ff 00 1 ee
01 3 34 12 a5 0 00
02 2 34 12 00 1 a5
02 2 34 52 00 1 c3

/* tb.f */
source/link_pkg.sv
source/cmd_pkg.sv
source/spi_rx.sv
source/cmd_parser.sv
source/cmd_exec.sv
source/spi_tx.sv
source/trs_link_top.sv
sim/link_checker.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_top -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
